// File: files.f
spi_regs_pkg.sv
spi_frame_rx.sv
cmd_credit_fifo.sv
reg_bank.sv
spi_reg_top.sv
tb_spi_reg.sv

// File: run_sim.sh
#!/bin/sh
# build and run the spi register testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_spi_reg
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_spi_reg)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "No errors"; then
  exit 0
fi
echo "simulation reported failure"
exit 1

// File: tb_spi_reg.sv
`timescale 1ns/100ps

module tb_spi_reg;

  // ------------------------------------------------------------
  // timing and run length
  localparam int clk_half      = 50;
  localparam int drive_dly     = 10;
  localparam int reset_cycles  = 4;
  // sclk half period in clk cycles
  localparam int half_period   = 5;
  localparam int settle_cycles = 20;
  localparam int n_frames      = 32;
  localparam int frame_bits    = 30;
  localparam int margin_cycles = 5000;
  localparam int watchdog_ns   =
    (n_frames * frame_bits * 2 * half_period + margin_cycles) * 2 * clk_half;

  logic        clk;
  logic        FPGA_RST;
  logic        spi_ssn;
  logic        spi_sclk;
  logic        spi_mosi;
  logic        stall;
  logic [15:0] irq_src;
  logic        spi_miso;
  logic        irq_o;

  int          errors;
  logic [31:0] lcg_state;
  // register image indexed by address
  logic [15:0] model_regs [0:7];
  logic [15:0] burst [0:7];

  // handoff from the read task to the compare process
  string       rd_name;
  logic [15:0] rd_exp;
  logic [15:0] rd_act;
  logic        rd_done;

  spi_reg_top dut (
    .clk        (clk),
    .FPGA_RST   (FPGA_RST),
    .spi_ssn_i  (spi_ssn),
    .spi_sclk_i (spi_sclk),
    .spi_mosi_i (spi_mosi),
    .stall_i    (stall),
    .irq_src_i  (irq_src),
    .spi_miso_o (spi_miso),
    .irq_o      (irq_o)
  );

  initial begin
    clk = 1'b0;
    forever #clk_half clk = ~clk;
  end

  // ------------------------------------------------------------
  // helpers
  task automatic check(input string name, input logic [15:0] expected,
                       input logic [15:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // n clock edges and then the drive offset
  task automatic step(input int n);
    repeat (n) @(posedge clk);
    #drive_dly;
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic rand_word(output logic [15:0] value);
    lcg_state = lcg_next(lcg_state);
    value = lcg_state[31:16];
  endtask

  // ------------------------------------------------------------
  // reference model
  function automatic logic [15:0] expected_read(input logic [6:0] addr);
    case (addr)
      spi_regs_pkg::REG_VERSION: return 16'h0304;
      spi_regs_pkg::REG_IRQ_CLR: return 16'h0000;
      default: begin
        if (addr < 7'd8) begin
          return model_regs[addr[2:0]];
        end
        return 16'h0000;
      end
    endcase
  endfunction

  task automatic model_write(input logic [6:0] addr, input logic [15:0] data);
    case (addr)
      spi_regs_pkg::REG_CTRL: begin
        // reset bit never reads back and wipes the latch
        model_regs[3] = data & 16'h7fff;
        if (data[15]) begin
          model_regs[2] = 16'h0000;
        end
      end
      spi_regs_pkg::REG_CONF:     model_regs[4] = data;
      spi_regs_pkg::REG_IRQ_MASK: model_regs[5] = data;
      spi_regs_pkg::REG_FILTER:   model_regs[7] = data;
      spi_regs_pkg::REG_IRQ_CLR:  model_regs[2] = model_regs[2] & ~data;
      default: ;
    endcase
  endtask

  // dropped write word raises the top source bit
  task automatic model_overrun();
    model_regs[2] = model_regs[2] | (model_regs[5] & 16'h8000);
  endtask

  task automatic drive_src(input logic [15:0] src);
    irq_src = src;
    model_regs[1] = src;
    model_regs[2] = model_regs[2] | (model_regs[5] & src);
  endtask

  // ------------------------------------------------------------
  // spi master in mode 0
  task automatic spi_bit(input logic mosi_bit, output logic miso_bit);
    spi_mosi = mosi_bit;
    step(half_period);
    miso_bit = spi_miso;
    spi_sclk = 1'b1;
    step(half_period);
    spi_sclk = 1'b0;
  endtask

  task automatic spi_frame_begin();
    spi_ssn = 1'b0;
    step(half_period);
  endtask

  task automatic spi_frame_end();
    step(half_period);
    spi_ssn = 1'b1;
    step(half_period);
  endtask

  task automatic spi_send_header(input logic rd, input logic [6:0] addr);
    logic [7:0] hdr;
    logic       dummy;
    int         i;
    hdr = {rd, addr};
    for (i = 7; i >= 0; i--) begin
      spi_bit(hdr[i], dummy);
    end
  endtask

  // words come from burst[0..n-1]
  task automatic spi_write_words(input logic [6:0] addr, input int n);
    logic dummy;
    int   i;
    int   b;
    spi_frame_begin();
    spi_send_header(1'b0, addr);
    for (i = 0; i < n; i++) begin
      for (b = 15; b >= 0; b--) begin
        spi_bit(burst[i][b], dummy);
      end
    end
    spi_frame_end();
    step(settle_cycles);
  endtask

  task automatic spi_write(input logic [6:0] addr, input logic [15:0] data);
    burst[0] = data;
    spi_write_words(addr, 1);
    model_write(addr, data);
  endtask

  task automatic spi_read(input logic [6:0] addr, input string name);
    logic [15:0] value;
    logic        bit_in;
    int          i;
    value = 16'h0000;
    spi_frame_begin();
    spi_send_header(1'b1, addr);
    for (i = 0; i < 16; i++) begin
      spi_bit(1'b0, bit_in);
      value = {value[14:0], bit_in};
    end
    spi_frame_end();
    rd_name = name;
    rd_exp  = expected_read(addr);
    rd_act  = value;
    rd_done = 1'b1;
    step(1);
    rd_done = 1'b0;
  endtask

  // compares every finished read against the model
  always @(posedge clk) begin
    if (rd_done) begin
      check(rd_name, rd_exp, rd_act);
    end
  end

  // ------------------------------------------------------------
  // tests
  initial begin
    logic [15:0] val;
    logic [15:0] src;
    int          i;
    errors    = 0;
    lcg_state = 32'h27cc;
    FPGA_RST  = 1'b1;
    spi_ssn   = 1'b1;
    spi_sclk  = 1'b0;
    spi_mosi  = 1'b0;
    stall     = 1'b0;
    irq_src   = 16'h0000;
    rd_done   = 1'b0;
    rd_name   = "";
    rd_exp    = 16'h0000;
    rd_act    = 16'h0000;
    for (i = 0; i < 8; i++) begin
      model_regs[i] = 16'h0000;
      burst[i]      = 16'h0000;
    end
    repeat (reset_cycles) @(posedge clk);
    #drive_dly;
    FPGA_RST = 1'b0;
    step(2);

    // reset values
    check("t1 irq_o", 16'h0000, 16'(irq_o));
    check("t1 miso", 16'h0000, 16'(spi_miso));
    spi_read(spi_regs_pkg::REG_VERSION, "t1 version");
    spi_read(spi_regs_pkg::REG_CTRL, "t1 ctrl");
    spi_read(spi_regs_pkg::REG_CONF, "t1 conf");
    spi_read(spi_regs_pkg::REG_IRQ_MASK, "t1 irq_mask");
    spi_read(spi_regs_pkg::REG_FILTER, "t1 filter");
    spi_read(spi_regs_pkg::REG_IRQ, "t1 irq");

    // write then read back and make sure read only targets ignore writes
    rand_word(val);
    spi_write(spi_regs_pkg::REG_CONF, val);
    rand_word(val);
    spi_write(spi_regs_pkg::REG_IRQ_MASK, val);
    rand_word(val);
    spi_write(spi_regs_pkg::REG_FILTER, val);
    spi_read(spi_regs_pkg::REG_CONF, "t2 conf");
    spi_read(spi_regs_pkg::REG_IRQ_MASK, "t2 irq_mask");
    spi_read(spi_regs_pkg::REG_FILTER, "t2 filter");
    rand_word(val);
    spi_write(spi_regs_pkg::REG_VERSION, val);
    spi_read(spi_regs_pkg::REG_VERSION, "t2 version");
    rand_word(val);
    spi_write(spi_regs_pkg::REG_STAT, val);
    spi_read(spi_regs_pkg::REG_STAT, "t2 stat");

    // interrupt latch set by a pulse and cleared by pattern and by ctrl reset
    rand_word(val);
    spi_write(spi_regs_pkg::REG_IRQ_MASK, val);
    rand_word(src);
    drive_src(src);
    step(3);
    drive_src(16'h0000);
    step(3);
    check("t3 irq_o set", 16'(model_regs[2] != 16'h0000), 16'(irq_o));
    spi_read(spi_regs_pkg::REG_IRQ, "t3 irq latched");
    rand_word(val);
    spi_write(spi_regs_pkg::REG_IRQ_CLR, val);
    spi_read(spi_regs_pkg::REG_IRQ, "t3 irq after clr");
    rand_word(val);
    spi_write(spi_regs_pkg::REG_CTRL, val | 16'h8000);
    spi_read(spi_regs_pkg::REG_IRQ, "t3 irq after ctrl rst");
    spi_read(spi_regs_pkg::REG_CTRL, "t3 ctrl");
    check("t3 irq_o clear", 16'(model_regs[2] != 16'h0000), 16'(irq_o));

    // live status with a steady source
    rand_word(src);
    drive_src(src);
    step(3);
    spi_read(spi_regs_pkg::REG_STAT, "t4 stat");
    drive_src(16'h0000);
    step(3);
    spi_write(spi_regs_pkg::REG_IRQ_CLR, 16'hffff);
    spi_read(spi_regs_pkg::REG_IRQ, "t4 irq cleared");

    // back-pressure with four credits and six words
    rand_word(val);
    spi_write(spi_regs_pkg::REG_IRQ_MASK, val | 16'h8000);
    for (i = 0; i < 6; i++) begin
      rand_word(burst[i]);
    end
    stall = 1'b1;
    spi_write_words(spi_regs_pkg::REG_FILTER, 6);
    for (i = 0; i < 6; i++) begin
      if (i < spi_regs_pkg::fifo_depth) begin
        model_write(spi_regs_pkg::REG_FILTER, burst[i]);
      end else begin
        model_overrun();
      end
    end
    stall = 1'b0;
    step(settle_cycles);
    spi_read(spi_regs_pkg::REG_FILTER, "t5 filter");
    spi_read(spi_regs_pkg::REG_IRQ, "t5 irq overrun");
    check("t5 irq_o", 16'(model_regs[2] != 16'h0000), 16'(irq_o));

    // three words in one frame where the last one sticks
    for (i = 0; i < 3; i++) begin
      rand_word(burst[i]);
    end
    spi_write_words(spi_regs_pkg::REG_CONF, 3);
    for (i = 0; i < 3; i++) begin
      model_write(spi_regs_pkg::REG_CONF, burst[i]);
    end
    spi_read(spi_regs_pkg::REG_CONF, "t6 conf");

    step(4);
    $display("checks done, %0d errors", errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // ------------------------------------------------------------
  // watchdog
  initial begin
    #watchdog_ns;
    $display("watchdog expired after %0d ns, tests did not finish", watchdog_ns);
    $display("checks done, %0d errors", errors);
    $display("Errors found");
    $finish;
  end

endmodule

// File: spi_reg_top.sv
`timescale 1ns/100ps

module spi_reg_top (
  input  logic                            clk,
  input  logic                            FPGA_RST,
  input  logic                            spi_ssn_i,
  input  logic                            spi_sclk_i,
  input  logic                            spi_mosi_i,
  input  logic                            stall_i,
  input  logic [spi_regs_pkg::data_w-1:0] irq_src_i,
  output logic                            spi_miso_o,
  output logic                            irq_o
);

  // ------------------------------------------------------------
  // decoder to buffer
  logic                            cmd_push;
  logic [spi_regs_pkg::cmd_w-1:0]  cmd_data;
  logic                            credit_ret;
  logic                            ovr_pulse;

  // buffer to register bank
  logic                            cmd_valid;
  logic [spi_regs_pkg::cmd_w-1:0]  cmd_head;
  logic                            cmd_pop;

  // read path back to the decoder
  logic [spi_regs_pkg::addr_w-1:0] rd_addr;
  logic [spi_regs_pkg::data_w-1:0] rd_data;

  spi_frame_rx u_rx (
    .clk          (clk),
    .FPGA_RST     (FPGA_RST),
    .spi_ssn_i    (spi_ssn_i),
    .spi_sclk_i   (spi_sclk_i),
    .spi_mosi_i   (spi_mosi_i),
    .spi_miso_o   (spi_miso_o),
    .cmd_push_o   (cmd_push),
    .cmd_data_o   (cmd_data),
    .ovr_pulse_o  (ovr_pulse),
    .rd_addr_o    (rd_addr),
    .credit_ret_i (credit_ret),
    .rd_data_i    (rd_data)
  );

  cmd_credit_fifo u_fifo (
    .clk          (clk),
    .FPGA_RST     (FPGA_RST),
    .push_i       (cmd_push),
    .push_data_i  (cmd_data),
    .pop_i        (cmd_pop),
    .valid_o      (cmd_valid),
    .head_o       (cmd_head),
    .credit_ret_o (credit_ret)
  );

  reg_bank u_regs (
    .clk         (clk),
    .FPGA_RST    (FPGA_RST),
    .cmd_valid_i (cmd_valid),
    .cmd_head_i  (cmd_head),
    .stall_i     (stall_i),
    .irq_src_i   (irq_src_i),
    .ovr_i       (ovr_pulse),
    .rd_addr_i   (rd_addr),
    .cmd_pop_o   (cmd_pop),
    .rd_data_o   (rd_data),
    .irq_o       (irq_o)
  );

endmodule

// File: reg_bank.sv
`timescale 1ns/100ps

module reg_bank (
  input  logic                            clk,
  input  logic                            FPGA_RST,
  input  logic                            cmd_valid_i,
  input  logic [spi_regs_pkg::cmd_w-1:0]  cmd_head_i,
  input  logic                            stall_i,
  input  logic [spi_regs_pkg::data_w-1:0] irq_src_i,
  input  logic                            ovr_i,
  input  logic [spi_regs_pkg::addr_w-1:0] rd_addr_i,
  output logic                            cmd_pop_o,
  output logic [spi_regs_pkg::data_w-1:0] rd_data_o,
  output logic                            irq_o
);

  // ------------------------------------------------------------
  // command decode
  logic [spi_regs_pkg::addr_w-1:0] wr_addr;
  logic [spi_regs_pkg::data_w-1:0] wr_data;

  // drain whenever something is queued and not held off
  assign cmd_pop_o = cmd_valid_i & ~stall_i;
  assign wr_addr   = cmd_head_i[spi_regs_pkg::cmd_w-1 -: spi_regs_pkg::addr_w];
  assign wr_data   = cmd_head_i[spi_regs_pkg::data_w-1:0];

  // writable registers
  logic [spi_regs_pkg::data_w-1:0] ctrl_q;
  logic [spi_regs_pkg::data_w-1:0] conf_q;
  logic [spi_regs_pkg::data_w-1:0] irq_mask_q;
  logic [spi_regs_pkg::data_w-1:0] filter_q;
  // clear strobe, lives one cycle
  logic [spi_regs_pkg::data_w-1:0] irq_clr_q;
  // live status, sampled each cycle
  logic [spi_regs_pkg::data_w-1:0] stat_q;
  logic [spi_regs_pkg::data_w-1:0] irq_q;
  logic                            ctrl_rst;

  assign ctrl_rst = ctrl_q[spi_regs_pkg::ctrl_rst_bit];

  always_ff @(posedge clk or posedge FPGA_RST) begin
    if (FPGA_RST) begin
      ctrl_q     <= '0;
      conf_q     <= '0;
      irq_mask_q <= '0;
      filter_q   <= '0;
      irq_clr_q  <= '0;
      stat_q     <= '0;
    end else begin
      stat_q    <= irq_src_i;
      irq_clr_q <= '0;
      // reset bit drops the cycle after it was set
      if (ctrl_rst) begin
        ctrl_q[spi_regs_pkg::ctrl_rst_bit] <= 1'b0;
      end
      if (cmd_pop_o) begin
        case (wr_addr)
          spi_regs_pkg::REG_CTRL:     ctrl_q     <= wr_data;
          spi_regs_pkg::REG_CONF:     conf_q     <= wr_data;
          spi_regs_pkg::REG_IRQ_MASK: irq_mask_q <= wr_data;
          spi_regs_pkg::REG_IRQ_CLR:  irq_clr_q  <= wr_data;
          spi_regs_pkg::REG_FILTER:   filter_q   <= wr_data;
          // version, stat, irq and unmapped are read only
          default: ;
        endcase
      end
    end
  end

  // ------------------------------------------------------------
  // interrupt latch
  logic [spi_regs_pkg::data_w-1:0] irq_in;
  logic [spi_regs_pkg::data_w-1:0] irq_kill;

  always_comb begin
    irq_in = irq_src_i;
    // write overrun joins the top source bit
    irq_in[spi_regs_pkg::irq_ovr_bit] = irq_src_i[spi_regs_pkg::irq_ovr_bit] | ovr_i;
  end

  assign irq_kill = irq_clr_q | {spi_regs_pkg::data_w{ctrl_rst}};

  // per bit rs latch, clear wins over set
  always_ff @(posedge clk or posedge FPGA_RST) begin
    if (FPGA_RST) begin
      irq_q <= '0;
    end else begin
      irq_q <= (irq_q | (irq_mask_q & irq_in)) & ~irq_kill;
    end
  end

  assign irq_o = |irq_q;

  // ------------------------------------------------------------
  // read mux
  always_comb begin
    case (spi_regs_pkg::reg_addr_e'(rd_addr_i))
      spi_regs_pkg::REG_VERSION:  rd_data_o = spi_regs_pkg::version_word;
      spi_regs_pkg::REG_STAT:     rd_data_o = stat_q;
      spi_regs_pkg::REG_IRQ:      rd_data_o = irq_q;
      spi_regs_pkg::REG_CTRL:     rd_data_o = ctrl_q;
      spi_regs_pkg::REG_CONF:     rd_data_o = conf_q;
      spi_regs_pkg::REG_IRQ_MASK: rd_data_o = irq_mask_q;
      spi_regs_pkg::REG_FILTER:   rd_data_o = filter_q;
      // irq_clr reads back zero, as does any hole
      default:                    rd_data_o = '0;
    endcase
  end

endmodule

// File: cmd_credit_fifo.sv
`timescale 1ns/100ps

module cmd_credit_fifo (
  input  logic                           clk,
  input  logic                           FPGA_RST,
  input  logic                           push_i,
  input  logic [spi_regs_pkg::cmd_w-1:0] push_data_i,
  input  logic                           pop_i,
  output logic                           valid_o,
  output logic [spi_regs_pkg::cmd_w-1:0] head_o,
  output logic                           credit_ret_o
);

  // ------------------------------------------------------------
  // storage
  logic [spi_regs_pkg::cmd_w-1:0]    mem [spi_regs_pkg::fifo_depth];
  logic [spi_regs_pkg::ptr_w-1:0]    wr_ptr;
  logic [spi_regs_pkg::ptr_w-1:0]    rd_ptr;
  // entries held, 0..fifo_depth
  logic [spi_regs_pkg::credit_w-1:0] count;
  logic                              full;
  logic                              do_push;
  logic                              do_pop;

  assign full    = (count == spi_regs_pkg::fifo_depth_c);
  assign valid_o = (count != '0);
  assign do_push = push_i & ~full;
  assign do_pop  = pop_i & valid_o;

  // head read straight from the array
  assign head_o = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  // ------------------------------------------------------------
  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk or posedge FPGA_RST) begin
    if (FPGA_RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // one credit back per entry drained, a cycle late
  always_ff @(posedge clk or posedge FPGA_RST) begin
    if (FPGA_RST) begin
      credit_ret_o <= 1'b0;
    end else begin
      credit_ret_o <= do_pop;
    end
  end

  // producer credits must keep this from ever happening
  a_no_push_full: assert property (@(posedge clk) disable iff (FPGA_RST)
    push_i |-> !full)
    else $error("push into full command buffer");

endmodule

// File: spi_frame_rx.sv
`timescale 1ns/100ps

module spi_frame_rx (
  input  logic                            clk,
  input  logic                            FPGA_RST,
  input  logic                            spi_ssn_i,
  input  logic                            spi_sclk_i,
  input  logic                            spi_mosi_i,
  output logic                            spi_miso_o,
  output logic                            cmd_push_o,
  output logic [spi_regs_pkg::cmd_w-1:0]  cmd_data_o,
  output logic                            ovr_pulse_o,
  output logic [spi_regs_pkg::addr_w-1:0] rd_addr_o,
  input  logic                            credit_ret_i,
  input  logic [spi_regs_pkg::data_w-1:0] rd_data_i
);

  // ------------------------------------------------------------
  // pin synchronisers with the oldest stage on the left
  logic [spi_regs_pkg::sync_stages-1:0] ssn_sync;
  logic [spi_regs_pkg::sync_stages-1:0] sclk_sync;
  logic [spi_regs_pkg::sync_stages-1:0] mosi_sync;
  logic                                 sclk_prev;
  logic                                 ssn_s;
  logic                                 sclk_s;
  logic                                 mosi_s;
  logic                                 sclk_rise;
  logic                                 sclk_fall;

  always_ff @(posedge clk or posedge FPGA_RST) begin
    if (FPGA_RST) begin
      // deselected until the host says otherwise
      ssn_sync  <= '1;
      sclk_sync <= '0;
      mosi_sync <= '0;
      sclk_prev <= 1'b0;
    end else begin
      ssn_sync  <= {ssn_sync[spi_regs_pkg::sync_stages-2:0], spi_ssn_i};
      sclk_sync <= {sclk_sync[spi_regs_pkg::sync_stages-2:0], spi_sclk_i};
      mosi_sync <= {mosi_sync[spi_regs_pkg::sync_stages-2:0], spi_mosi_i};
      sclk_prev <= sclk_s;
    end
  end

  assign ssn_s  = ssn_sync[spi_regs_pkg::sync_stages-1];
  assign sclk_s = sclk_sync[spi_regs_pkg::sync_stages-1];
  assign mosi_s = mosi_sync[spi_regs_pkg::sync_stages-1];
  // mode 0 samples on rise and shifts miso on fall
  assign sclk_rise = sclk_s & ~sclk_prev;
  assign sclk_fall = ~sclk_s & sclk_prev;

  // ------------------------------------------------------------
  // frame decoder
  spi_regs_pkg::rx_state_e              state;
  // counts header bits 0..7 and then data bits 0..15
  logic [3:0]                           bit_cnt;
  // header byte with the read flag landing in the top bit
  logic [spi_regs_pkg::addr_w:0]        hdr_sr;
  logic [spi_regs_pkg::data_w-1:0]      data_sr;
  logic [spi_regs_pkg::data_w-1:0]      word;
  logic [spi_regs_pkg::data_w-1:0]      miso_sr;
  logic                                 rd_started;
  logic                                 hdr_last;
  logic                                 word_done;
  logic [spi_regs_pkg::credit_w-1:0]    credit;

  assign hdr_last  = (state == spi_regs_pkg::ADDR) & sclk_rise &
                     (bit_cnt == 4'(spi_regs_pkg::addr_w));
  assign word_done = (state == spi_regs_pkg::WDATA) & sclk_rise &
                     (bit_cnt == 4'(spi_regs_pkg::data_w - 1));
  // word including the bit arriving now
  assign word = {data_sr[spi_regs_pkg::data_w-2:0], mosi_s};

  // header and data shift registers
  always_ff @(posedge clk) begin
    if (sclk_rise && state == spi_regs_pkg::ADDR) begin
      hdr_sr <= {hdr_sr[spi_regs_pkg::addr_w-1:0], mosi_s};
    end
    if (sclk_rise && state == spi_regs_pkg::WDATA) begin
      data_sr <= word;
    end
  end

  always_ff @(posedge clk or posedge FPGA_RST) begin
    if (FPGA_RST) begin
      state      <= spi_regs_pkg::IDLE;
      bit_cnt    <= '0;
      rd_started <= 1'b0;
      miso_sr    <= '0;
    end else if (ssn_s) begin
      // deselect aborts any frame
      state      <= spi_regs_pkg::IDLE;
      bit_cnt    <= '0;
      rd_started <= 1'b0;
      miso_sr    <= '0;
    end else begin
      case (state)
        spi_regs_pkg::IDLE: begin
          state   <= spi_regs_pkg::ADDR;
          bit_cnt <= '0;
        end
        spi_regs_pkg::ADDR: begin
          if (hdr_last) begin
            bit_cnt <= '0;
            // first header bit set means read
            if (hdr_sr[spi_regs_pkg::addr_w-1]) begin
              state   <= spi_regs_pkg::RDATA;
              miso_sr <= rd_data_i;
            end else begin
              state <= spi_regs_pkg::WDATA;
            end
          end else if (sclk_rise) begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        spi_regs_pkg::WDATA: begin
          // wraps every 16 bits for back to back words
          if (sclk_rise) begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        default: begin
          // msb is already on the pin so the first shift waits for a rise
          if (sclk_rise) begin
            rd_started <= 1'b1;
          end else if (sclk_fall && rd_started) begin
            miso_sr <= {miso_sr[spi_regs_pkg::data_w-2:0], 1'b0};
          end
        end
      endcase
    end
  end

  assign spi_miso_o = miso_sr[spi_regs_pkg::data_w-1];

  // header address is still shifting in while in ADDR
  assign rd_addr_o = (state == spi_regs_pkg::ADDR) ?
                     {hdr_sr[spi_regs_pkg::addr_w-2:0], mosi_s} :
                     hdr_sr[spi_regs_pkg::addr_w-1:0];

  // ------------------------------------------------------------
  // write issue under credits
  assign cmd_push_o  = word_done & (credit != '0);
  assign ovr_pulse_o = word_done & (credit == '0);
  assign cmd_data_o  = {hdr_sr[spi_regs_pkg::addr_w-1:0], word};

  always_ff @(posedge clk or posedge FPGA_RST) begin
    if (FPGA_RST) begin
      credit <= spi_regs_pkg::fifo_depth_c;
    end else begin
      case ({credit_ret_i, cmd_push_o})
        2'b10:   credit <= credit + 1'b1;
        2'b01:   credit <= credit - 1'b1;
        default: credit <= credit;
      endcase
    end
  end

  // returns come only for entries this side pushed
  // a push without credit wraps the count above the depth
  a_credit_max: assert property (@(posedge clk) disable iff (FPGA_RST)
    credit <= spi_regs_pkg::fifo_depth_c)
    else $error("credit count above buffer depth");

endmodule

// File: spi_regs_pkg.sv
package spi_regs_pkg;

  // ------------------------------------------------------------
  // widths
  // register and spi data word
  localparam int data_w = 16;
  // register address, low seven bits of the header byte
  localparam int addr_w = 7;
  // one queued write, address above data
  localparam int cmd_w = addr_w + data_w;

  // ------------------------------------------------------------
  // command buffer and credits
  localparam int fifo_depth = 4;
  localparam int ptr_w = $clog2(fifo_depth);
  localparam int credit_w = 3;
  // depth as a counter value, also the credit count out of reset
  localparam logic [credit_w-1:0] fifo_depth_c = credit_w'(fifo_depth);

  // spi pin synchroniser depth
  localparam int sync_stages = 2;

  // ------------------------------------------------------------
  // register contents
  localparam logic [data_w-1:0] version_word = 16'h0304;
  // ctrl bit that resets the interrupt latch, self clearing
  localparam int ctrl_rst_bit = 15;
  // irq bit that also carries the write overrun source
  localparam int irq_ovr_bit = 15;

  // register map
  typedef enum logic [addr_w-1:0] {
    REG_VERSION  = 7'd0,
    REG_STAT     = 7'd1,
    REG_IRQ      = 7'd2,
    REG_CTRL     = 7'd3,
    REG_CONF     = 7'd4,
    REG_IRQ_MASK = 7'd5,
    REG_IRQ_CLR  = 7'd6,
    REG_FILTER   = 7'd7
  } reg_addr_e;

  // frame decoder states
  typedef enum logic [1:0] {
    IDLE,
    ADDR,
    WDATA,
    RDATA
  } rx_state_e;

endpackage
